// File: common/pdp_pkg.sv
/* pdp shared definitions
   element and partial widths, config types, pooling enums */
package pdp_pkg;

  // ====================
  // widths
  // ====================
  localparam int BWPE           = 8;        // element width
  localparam int SUM_W          = BWPE + 6; // partial width, room for 8x8 window sum
  localparam int RECIP_W        = 17;       // 1.16 fixed point
  localparam int DIM_W          = 13;       // cube dimension
  localparam int KER_W          = 3;        // kernel size
  localparam int LBUF_DEPTH_DEF = 64;       // output columns held per line

  // ====================
  // types
  // ====================
  typedef logic signed [BWPE-1:0]  elem_t;  // one input/output element
  typedef logic signed [SUM_W-1:0] sum_t;   // partial or window sum
  typedef logic [RECIP_W-1:0]      recip_t; // unsigned reciprocal
  typedef logic [DIM_W-1:0]        dim_t;   // dimension minus one
  typedef logic [KER_W-1:0]        ker_t;   // kernel size minus one

  typedef enum logic [1:0] {
    POOL_AVG = 2'd0,
    POOL_MAX = 2'd1,
    POOL_MIN = 2'd2
  } pool_type_e;

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_RUN  = 1'b1
  } op_state_e;

  // merge one new value b into running value a, used by both pooling stages
  function automatic sum_t pool_merge(pool_type_e ptype, sum_t a, sum_t b);
    sum_t r;
    case (ptype)
      POOL_MAX: r = (b > a) ? b : a; // signed compare
      POOL_MIN: r = (b < a) ? b : a;
      default:  r = a + b;           // average sums first
    endcase
    return r;
  endfunction

endpackage

// File: common/pdp_elem_if.sv
/* tagged element stream, input stage to horizontal stage */
`timescale 1ns/1ps

interface pdp_elem_if;
  import pdp_pkg::*;

  logic valid;
  logic ready;
  sum_t data;       // element extended to partial width
  logic col_first;  // first column of kernel window
  logic col_last;   // last column of kernel window
  logic row_first;  // first row of kernel window
  logic row_last;   // last row of kernel window
  logic line_end;   // last element of input line
  logic surf_end;   // last element of surface

  modport source (
    output valid, data, col_first, col_last, row_first, row_last, line_end, surf_end,
    input  ready
  );

  modport sink (
    input  valid, data, col_first, col_last, row_first, row_last, line_end, surf_end,
    output ready
  );

endinterface

// File: common/pdp_part_if.sv
/* horizontal partial stream, horizontal stage to vertical stage */
`timescale 1ns/1ps

interface pdp_part_if;
  import pdp_pkg::*;

  logic valid;
  logic ready;
  sum_t data;       // kernel_width reduced partial
  logic row_first;  // first row of kernel window
  logic row_last;   // last row of kernel window
  logic line_end;   // last partial of line
  logic surf_end;   // last partial of surface

  modport source (
    output valid, data, row_first, row_last, line_end, surf_end,
    input  ready
  );

  modport sink (
    input  valid, data, row_first, row_last, line_end, surf_end,
    output ready
  );

endinterface

// File: src/pdp_preproc.sv
/* pdp input stage
   source select, run state, window position tagging */
`timescale 1ns/1ps

module pdp_preproc (
  input  logic           nvdla_core_clk,
  input  logic           nvdla_core_rstn,
  input  logic           rdma_valid,
  input  pdp_pkg::elem_t rdma_pd,
  output logic           rdma_ready,
  input  logic           sdp_valid,
  input  pdp_pkg::elem_t sdp_pd,
  output logic           sdp_ready,
  input  logic           flying_mode,
  input  logic           op_en,
  input  pdp_pkg::ker_t  kernel_width,
  input  pdp_pkg::ker_t  kernel_height,
  input  pdp_pkg::dim_t  cube_in_width,
  input  pdp_pkg::dim_t  cube_in_height,
  pdp_elem_if.source     elem
);
  import pdp_pkg::*;

  op_state_e state;
  dim_t      col_cnt;   // input column
  dim_t      row_cnt;   // input row
  ker_t      kw_cnt;    // column phase in kernel
  ker_t      kh_cnt;    // row phase in kernel
  logic      sel_valid;
  elem_t     sel_pd;
  logic      can_load;
  logic      take;
  logic      col_last;
  logic      row_last;
  logic      line_end;
  logic      surf_end;

  assign sel_valid = flying_mode ? sdp_valid : rdma_valid;
  assign sel_pd    = flying_mode ? sdp_pd : rdma_pd;
  assign can_load  = (state == ST_RUN) && (!elem.valid || elem.ready); // slot empty or draining
  assign rdma_ready = can_load && !flying_mode;
  assign sdp_ready  = can_load && flying_mode;
  assign take       = can_load && sel_valid;

  // position of the element being accepted
  assign col_last = (kw_cnt == kernel_width);
  assign row_last = (kh_cnt == kernel_height);
  assign line_end = (col_cnt == cube_in_width);
  assign surf_end = line_end && (row_cnt == cube_in_height);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state   <= ST_IDLE;
      col_cnt <= '0;
      row_cnt <= '0;
      kw_cnt  <= '0;
      kh_cnt  <= '0;
    end else begin
      if (state == ST_IDLE && op_en) begin
        state <= ST_RUN;
      end else if (take && surf_end) begin
        state <= ST_IDLE;                                 // whole surface taken
      end
      if (take) begin
        kw_cnt  <= col_last ? '0 : kw_cnt + 1'b1;
        col_cnt <= line_end ? '0 : col_cnt + 1'b1;
        if (line_end) begin
          kh_cnt  <= row_last ? '0 : kh_cnt + 1'b1;
          row_cnt <= surf_end ? '0 : row_cnt + 1'b1;
        end
      end
    end
  end

  // output register valid
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      elem.valid <= 1'b0;
    end else if (take) begin
      elem.valid <= 1'b1;
    end else if (elem.ready) begin
      elem.valid <= 1'b0;
    end
  end

  // payload and tags
  always_ff @(posedge nvdla_core_clk) begin
    if (take) begin
      elem.data      <= sum_t'(sel_pd);  // sign extend to partial width
      elem.col_first <= (kw_cnt == '0);
      elem.col_last  <= col_last;
      elem.row_first <= (kh_cnt == '0);
      elem.row_last  <= row_last;
      elem.line_end  <= line_end;
      elem.surf_end  <= surf_end;
    end
  end

endmodule

// File: cal1d/pdp_cal1d.sv
/* pdp horizontal pooling
   reduces kernel_width neighbouring elements to one partial */
`timescale 1ns/1ps

module pdp_cal1d (
  input  logic                nvdla_core_clk,
  input  logic                nvdla_core_rstn,
  input  pdp_pkg::pool_type_e pooling_type,
  pdp_elem_if.sink            elem,
  pdp_part_if.source          part
);
  import pdp_pkg::*;

  sum_t acc;      // running value inside window
  sum_t merged;   // acc combined with incoming element
  logic take;

  // only the window closing element needs the output slot
  assign elem.ready = !elem.col_last || !part.valid || part.ready;
  assign take       = elem.valid && elem.ready;

  assign merged = elem.col_first ? elem.data : pool_merge(pooling_type, acc, elem.data);

  always_ff @(posedge nvdla_core_clk) begin
    if (take && !elem.col_last) begin
      acc <= merged;                // keep accumulating
    end
  end

  // ====================
  // partial out
  // ====================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      part.valid <= 1'b0;
    end else if (take && elem.col_last) begin
      part.valid <= 1'b1;
    end else if (part.ready) begin
      part.valid <= 1'b0;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (take && elem.col_last) begin
      part.data      <= merged;
      part.row_first <= elem.row_first;   // row tags pass through
      part.row_last  <= elem.row_last;
      part.line_end  <= elem.line_end;
      part.surf_end  <= elem.surf_end;
    end
  end

endmodule

// File: cal2d/pdp_line_buffer.sv
/* pdp line buffer
   one row of partials, async read, sync write */
`timescale 1ns/1ps

module pdp_line_buffer #(
  parameter int LBUF_DEPTH = pdp_pkg::LBUF_DEPTH_DEF
) (
  input  logic                          nvdla_core_clk,
  input  logic                          wr_en,
  input  logic [$clog2(LBUF_DEPTH)-1:0] wr_addr,
  input  pdp_pkg::sum_t                 wr_data,
  input  logic [$clog2(LBUF_DEPTH)-1:0] rd_addr,
  output pdp_pkg::sum_t                 rd_data
);

  pdp_pkg::sum_t mem [LBUF_DEPTH];  // indexed by output column

  always_ff @(posedge nvdla_core_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  assign rd_data = mem[rd_addr];  // combinational read

endmodule

// File: cal2d/pdp_cal2d.sv
/* pdp vertical pooling
   merges kernel_height rows through a line buffer, scales average, drives output */
`timescale 1ns/1ps

module pdp_cal2d #(
  parameter int LBUF_DEPTH = pdp_pkg::LBUF_DEPTH_DEF
) (
  input  logic                nvdla_core_clk,
  input  logic                nvdla_core_rstn,
  input  pdp_pkg::pool_type_e pooling_type,
  input  pdp_pkg::recip_t     recip_cfg,
  pdp_part_if.sink            part,
  output logic                out_valid,
  input  logic                out_ready,
  output pdp_pkg::elem_t      out_pd,
  output logic                done
);
  import pdp_pkg::*;

  localparam int AW     = $clog2(LBUF_DEPTH);
  localparam int PROD_W = SUM_W + RECIP_W + 1;  // signed sum times unsigned recip

  logic [AW-1:0]           col_cnt;   // output column
  sum_t                    stored;    // partial from previous rows
  sum_t                    merged;
  logic                    take;
  logic                    out_surf;  // current output closes surface
  logic signed [PROD_W-1:0] prod;
  logic signed [PROD_W-1:0] rnd;
  elem_t                   scaled;

  // rows that only update the line buffer never wait on output
  assign part.ready = !part.row_last || !out_valid || out_ready;
  assign take       = part.valid && part.ready;

  assign merged = part.row_first ? part.data : pool_merge(pooling_type, stored, part.data);

  // ====================
  // line memory
  // ====================
  pdp_line_buffer #(
    .LBUF_DEPTH (LBUF_DEPTH)
  ) u_lbuf (
    .nvdla_core_clk (nvdla_core_clk),
    .wr_en          (take && !part.row_last),
    .wr_addr        (col_cnt),
    .wr_data        (merged),
    .rd_addr        (col_cnt),
    .rd_data        (stored)
  );

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      col_cnt <= '0;
    end else if (take) begin
      col_cnt <= part.line_end ? '0 : col_cnt + 1'b1;
    end
  end

  // ====================
  // average scaling
  // ====================
  assign prod   = merged * $signed({1'b0, recip_cfg});
  assign rnd    = prod + {{(PROD_W-16){1'b0}}, 1'b1, 15'd0};  // round half up
  assign scaled = (pooling_type == POOL_AVG) ? elem_t'(rnd >>> 16) : merged[BWPE-1:0];

  // ====================
  // output register
  // ====================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      out_valid <= 1'b0;
      done      <= 1'b0;
    end else begin
      if (take && part.row_last) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
      done <= out_valid && out_ready && out_surf;  // one cycle after last beat
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (take && part.row_last) begin
      out_pd   <= scaled;
      out_surf <= part.surf_end;
    end
  end

endmodule

// File: src/pdp_core.sv
/* pdp core, planar pooling data path
   input select, horizontal then vertical pooling */
`timescale 1ns/1ps

module pdp_core #(
  parameter int LBUF_DEPTH = pdp_pkg::LBUF_DEPTH_DEF  // max output columns per line
) (
  input  logic                 nvdla_core_clk,
  input  logic                 nvdla_core_rstn,
  input  logic                 rdma_valid,      // memory read stream
  input  pdp_pkg::elem_t       rdma_pd,
  output logic                 rdma_ready,
  input  logic                 sdp_valid,       // on-the-fly stream
  input  pdp_pkg::elem_t       sdp_pd,
  output logic                 sdp_ready,
  input  logic                 flying_mode,     // 1 selects sdp
  input  logic                 op_en,           // start strobe
  input  pdp_pkg::pool_type_e  pooling_type,
  input  pdp_pkg::ker_t        kernel_width,
  input  pdp_pkg::ker_t        kernel_height,
  input  pdp_pkg::dim_t        cube_in_width,
  input  pdp_pkg::dim_t        cube_in_height,
  input  pdp_pkg::recip_t      recip_cfg,       // average scale
  output logic                 out_valid,
  input  logic                 out_ready,
  output pdp_pkg::elem_t       out_pd,
  output logic                 done             // end of operation pulse
);

  pdp_elem_if u_elem_if ();  // preproc -> cal1d
  pdp_part_if u_part_if ();  // cal1d -> cal2d

  // ====================
  // input stage
  // ====================
  pdp_preproc u_preproc (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .rdma_valid      (rdma_valid),
    .rdma_pd         (rdma_pd),
    .rdma_ready      (rdma_ready),
    .sdp_valid       (sdp_valid),
    .sdp_pd          (sdp_pd),
    .sdp_ready       (sdp_ready),
    .flying_mode     (flying_mode),
    .op_en           (op_en),
    .kernel_width    (kernel_width),
    .kernel_height   (kernel_height),
    .cube_in_width   (cube_in_width),
    .cube_in_height  (cube_in_height),
    .elem            (u_elem_if.source)
  );

  // ====================
  // pooling 1d
  // ====================
  pdp_cal1d u_cal1d (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .pooling_type    (pooling_type),
    .elem            (u_elem_if.sink),
    .part            (u_part_if.source)
  );

  // ====================
  // pooling 2d
  // ====================
  pdp_cal2d #(
    .LBUF_DEPTH (LBUF_DEPTH)
  ) u_cal2d (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .pooling_type    (pooling_type),
    .recip_cfg       (recip_cfg),
    .part            (u_part_if.sink),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .out_pd          (out_pd),
    .done            (done)
  );

endmodule

// File: verif/pdp_core_checker.sv
/* pdp core protocol checker
   bound to the core top level ports */
`timescale 1ns/1ps

module pdp_core_checker (
  input logic           nvdla_core_clk,
  input logic           nvdla_core_rstn,
  input logic           rdma_ready,
  input logic           sdp_ready,
  input logic           op_en,
  input logic           out_valid,
  input logic           out_ready,
  input pdp_pkg::elem_t out_pd,
  input logic           done
);

  int unsigned fail_count = 0;  // failed assertions, polled by the testbench
  logic        op_seen;         // op_en seen since reset

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_seen <= 1'b0;
    end else if (op_en) begin
      op_seen <= 1'b1;
    end
  end

  // ====================
  // output stream
  // ====================
  stall_stable: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    out_valid && !out_ready |=> out_valid && $stable(out_pd))
    else begin
      fail_count++;
      $error("out_valid dropped or out_pd changed while stalled");
    end

  done_not_stalled: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    $rose(done) |-> !(out_valid && !out_ready))
    else begin
      fail_count++;
      $error("done rose while the output was stalled");
    end

  idle_until_op: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !op_seen |-> !out_valid && !done)
    else begin
      fail_count++;
      $error("output activity before the first op_en");
    end

  // ====================
  // input select
  // ====================
  one_source: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !(rdma_ready && sdp_ready))
    else begin
      fail_count++;
      $error("rdma_ready and sdp_ready high together");
    end

endmodule

// File: verif/tb_pdp_core.sv
/* pdp core testbench
   pooling runs checked against a window reference model */
`timescale 1ns/1ps

module tb_pdp_core;
  import pdp_pkg::*;

  localparam int TIMEOUT_CYC = 2000;  // cycles per wait loop

  logic       nvdla_core_clk;
  logic       nvdla_core_rstn;
  logic       rdma_valid;
  logic       rdma_ready;
  elem_t      rdma_pd;
  logic       sdp_valid;
  logic       sdp_ready;
  elem_t      sdp_pd;
  logic       flying_mode;
  logic       op_en;
  pool_type_e pooling_type;
  ker_t       kernel_width;
  ker_t       kernel_height;
  dim_t       cube_in_width;
  dim_t       cube_in_height;
  recip_t     recip_cfg;
  logic       out_valid;
  logic       out_ready;
  elem_t      out_pd;
  logic       done;

  elem_t in_mem [256];        // surface, raster order
  elem_t exp_q [$];           // expected outputs in order
  elem_t exp_v;
  int    done_cnt   = 0;
  logic  rand_ready = 1'b0;   // random back-pressure on
  logic  fly_run    = 1'b0;   // sdp stream selected

  pdp_core UUT (.*);

  bind pdp_core pdp_core_checker u_checker (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .rdma_ready      (rdma_ready),
    .sdp_ready       (sdp_ready),
    .op_en           (op_en),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .out_pd          (out_pd),
    .done            (done)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #4 nvdla_core_clk = ~nvdla_core_clk;  // 8 ns period
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  // ====================
  // reference model
  // ====================
  function automatic elem_t window_result(pool_type_e pt, int kw, int kh, int w,
                                          int ox, int oy, recip_t rc);
    longint acc;
    longint v;
    int     x;
    int     y;
    acc = 0;
    for (y = 0; y < kh; y++) begin
      for (x = 0; x < kw; x++) begin
        v = longint'(in_mem[(oy * kh + y) * w + ox * kw + x]);  // signed element
        if (x == 0 && y == 0) begin
          acc = v;
        end else if (pt == POOL_MAX && v > acc) begin
          acc = v;
        end else if (pt == POOL_MIN && v < acc) begin
          acc = v;
        end else if (pt == POOL_AVG) begin
          acc = acc + v;
        end
      end
    end
    if (pt == POOL_AVG) begin
      acc = (acc * longint'(rc) + 64'sd32768) >>> 16;  // scale, round, shift
    end
    return elem_t'(acc[BWPE-1:0]);
  endfunction

  // out_ready moves 1 ns after the edge
  always @(posedge nvdla_core_clk) begin
    #1;
    out_ready = rand_ready ? ($urandom % 2 == 0) : 1'b1;
  end

  // ====================
  // scoreboard, sampled mid cycle
  // ====================
  always @(negedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      if (UUT.u_checker.fail_count != 0) begin
        fail_now("a protocol assertion in the checker failed");
      end
      assert (!(fly_run && rdma_ready))
        else fail_now($sformatf("CHECK FAILED at %0t: rdma_ready high in flying mode", $time));
      if (done) begin
        done_cnt++;
        assert (exp_q.size() == 0)  // done only after the last output
          else fail_now($sformatf("CHECK FAILED at %0t: done with %0d outputs still due",
                                  $time, exp_q.size()));
      end
      if (out_valid && out_ready) begin  // beat transfers at next edge
        if (exp_q.size() == 0) begin
          fail_now("output beat arrived with nothing left to expect");
        end
        exp_v = exp_q.pop_front();
        assert (out_pd == exp_v)
          else fail_now($sformatf("CHECK FAILED at %0t: out_pd expected %0d got %0d",
                                  $time, exp_v, out_pd));
      end
    end
  end

  // ====================
  // stimulus
  // ====================
  task automatic send_elems(input bit fly, input int n);
    int i;
    int wait_cnt;
    for (i = 0; i < n; i++) begin
      if (fly) begin
        sdp_valid = 1'b1;
        sdp_pd    = in_mem[i];
      end else begin
        rdma_valid = 1'b1;
        rdma_pd    = in_mem[i];
      end
      wait_cnt = 0;
      @(negedge nvdla_core_clk);
      while (!(fly ? sdp_ready : rdma_ready)) begin
        wait_cnt++;
        if (wait_cnt > TIMEOUT_CYC) begin
          fail_now("timeout: an input element was never accepted");
        end
        @(negedge nvdla_core_clk);
      end
      @(posedge nvdla_core_clk);  // beat taken here
      #1;
    end
    rdma_valid = 1'b0;
    sdp_valid  = 1'b0;
  endtask

  task automatic run_surface(input pool_type_e pt, input int kw, input int kh, input int w,
                             input int h, input recip_t rc, input bit fly, input bit rnd_rdy);
    int i;
    int ox;
    int oy;
    int wait_cnt;
    int done_before;
    pooling_type   = pt;
    kernel_width   = ker_t'(kw - 1);   // sizes minus one
    kernel_height  = ker_t'(kh - 1);
    cube_in_width  = dim_t'(w - 1);
    cube_in_height = dim_t'(h - 1);
    recip_cfg      = rc;
    flying_mode    = fly;
    fly_run        = fly;
    rand_ready     = rnd_rdy;
    for (i = 0; i < w * h; i++) begin
      in_mem[i] = elem_t'($urandom);  // both signs
    end
    for (oy = 0; oy < h / kh; oy++) begin
      for (ox = 0; ox < w / kw; ox++) begin
        exp_q.push_back(window_result(pt, kw, kh, w, ox, oy, rc));
      end
    end
    done_before = done_cnt;
    op_en = 1'b1;
    @(posedge nvdla_core_clk);
    #1;
    op_en = 1'b0;
    send_elems(fly, w * h);
    wait_cnt = 0;
    while (done_cnt == done_before) begin
      wait_cnt++;
      if (wait_cnt > TIMEOUT_CYC) begin
        fail_now("timeout: done did not pulse after the last input");
      end
      @(posedge nvdla_core_clk);
    end
    repeat (4) @(posedge nvdla_core_clk);  // room for a stray second pulse
    #1;
    assert (done_cnt == done_before + 1)
      else fail_now($sformatf("CHECK FAILED at %0t: done pulsed %0d times, expected 1",
                              $time, done_cnt - done_before));
    assert (exp_q.size() == 0)
      else fail_now($sformatf("CHECK FAILED at %0t: %0d expected outputs never arrived",
                              $time, exp_q.size()));
  endtask

  initial begin
    void'($urandom(56));
    nvdla_core_rstn = 1'b0;
    rdma_valid      = 1'b0;
    rdma_pd         = '0;
    sdp_valid       = 1'b0;
    sdp_pd          = '0;
    flying_mode     = 1'b0;
    op_en           = 1'b0;
    pooling_type    = POOL_MAX;
    kernel_width    = '0;
    kernel_height   = '0;
    cube_in_width   = '0;
    cube_in_height  = '0;
    recip_cfg       = '0;
    out_ready       = 1'b1;
    repeat (16) @(posedge nvdla_core_clk);
    #1;
    nvdla_core_rstn = 1'b1;
    @(posedge nvdla_core_clk);
    #1;
    run_surface(POOL_MAX, 2, 2, 8, 4, 17'd0, 1'b0, 1'b0);      // 2x2 max, rdma
    run_surface(POOL_MIN, 3, 1, 6, 3, 17'd0, 1'b0, 1'b0);      // 3x1 min
    run_surface(POOL_AVG, 2, 2, 8, 4, 17'd16384, 1'b0, 1'b0);  // quarter scale
    run_surface(POOL_MAX, 2, 2, 4, 4, 17'd0, 1'b1, 1'b0);      // sdp stream
    run_surface(POOL_MAX, 2, 2, 8, 6, 17'd0, 1'b0, 1'b1);      // random back-pressure
    run_surface(POOL_AVG, 3, 3, 6, 6, 17'd7282, 1'b1, 1'b1);   // ninth scale, sdp, stalls
    if (UUT.u_checker.fail_count != 0) begin
      fail_now("a protocol assertion in the checker failed");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

// File: sources.f
common/pdp_pkg.sv
common/pdp_elem_if.sv
common/pdp_part_if.sv
src/pdp_preproc.sv
cal1d/pdp_cal1d.sv
cal2d/pdp_line_buffer.sv
cal2d/pdp_cal2d.sv
src/pdp_core.sv
verif/pdp_core_checker.sv
verif/tb_pdp_core.sv

// File: Makefile
TOP = tb_pdp_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
